/* include/decoder_defs.svh */
`ifndef DECODER_DEFS_SVH
`define DECODER_DEFS_SVH

// machine word
`define DATA_W      32

// instruction field widths
`define OPCODE_W    6
`define FUNCT_W     6
`define REG_IDX_W   5
`define IMM_W       16
`define JUMP_IDX_W  26

`define LINK_REG    31  // $ra

`endif

/* src/mipsIsaPkg.sv */
`include "decoder_defs.svh"

package mipsIsaPkg;

    typedef enum logic [`OPCODE_W-1:0] {
        opSpecial = 6'b000000,
        opRegimm  = 6'b000001,
        opJ       = 6'b000010,
        opJal     = 6'b000011,
        opBeq     = 6'b000100,
        opBne     = 6'b000101,
        opBlez    = 6'b000110,
        opBgtz    = 6'b000111,
        opAddi    = 6'b001000,
        opAddiu   = 6'b001001,
        opSlti    = 6'b001010,
        opSltiu   = 6'b001011,
        opAndi    = 6'b001100,
        opOri     = 6'b001101,
        opXori    = 6'b001110,
        opLui     = 6'b001111,
        opLb      = 6'b100000,
        opLh      = 6'b100001,
        opLw      = 6'b100011,
        opLbu     = 6'b100100,
        opLhu     = 6'b100101,
        opSb      = 6'b101000,
        opSh      = 6'b101001,
        opSw      = 6'b101011
    } opcode_e;

    // rt field of REGIMM, bit 4 marks the linking forms
    typedef enum logic [`REG_IDX_W-1:0] {
        riBltz   = 5'b00000,
        riBgez   = 5'b00001,
        riBltzal = 5'b10000,
        riBgezal = 5'b10001
    } regimm_e;

    typedef enum logic [`FUNCT_W-1:0] {
        fnSll     = 6'b000000,
        fnSrl     = 6'b000010,
        fnSra     = 6'b000011,
        fnSllv    = 6'b000100,
        fnSrlv    = 6'b000110,
        fnSrav    = 6'b000111,
        fnJr      = 6'b001000,
        fnJalr    = 6'b001001,
        fnSyscall = 6'b001100,
        fnBreak   = 6'b001101,
        fnAdd     = 6'b100000,
        fnAddu    = 6'b100001,
        fnSub     = 6'b100010,
        fnSubu    = 6'b100011,
        fnAnd     = 6'b100100,
        fnOr      = 6'b100101,
        fnXor     = 6'b100110,
        fnNor     = 6'b100111,
        fnSlt     = 6'b101010,
        fnSltu    = 6'b101011
    } funct_e;

    typedef struct packed {
        logic [`REG_IDX_W-1:0] rd;
        logic [4:0]            shamt;
        funct_e                funct;
    } rLow_t;

    // low half is either rd/shamt/funct or imm16
    typedef union packed {
        rLow_t             r;
        logic [`IMM_W-1:0] imm16;
    } lowHalf_t;

    typedef struct packed {
        opcode_e               opcode;
        logic [`REG_IDX_W-1:0] rs;
        logic [`REG_IDX_W-1:0] rt;
        lowHalf_t              low;
    } instrFields_t;

endpackage

/* src/decodeCtrlPkg.sv */
`include "decoder_defs.svh"

package decodeCtrlPkg;

    typedef logic [`DATA_W-1:0] word_t;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluNor,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra
    } aluOp_e;

    typedef enum logic [2:0] {
        cmpNone,
        cmpEq,
        cmpNe,
        cmpLtz,
        cmpGez,
        cmpLez,
        cmpGtz
    } cmpOp_e;

    typedef enum logic [1:0] {
        wbNone,
        wbAlu,
        wbMem,
        wbPc
    } wbSrc_e;

    typedef enum logic [1:0] {
        memByte,
        memHalf,
        memWord
    } memWidth_e;

    typedef enum logic [1:0] {
        excNone,
        excSyscall,
        excBreak,
        excUnknown
    } exc_e;

    typedef struct packed {
        logic [`REG_IDX_W-1:0] regRead1;
        logic [`REG_IDX_W-1:0] regRead2;
        logic [`REG_IDX_W-1:0] destReg;
        wbSrc_e                wbSrc;
        aluOp_e                aluOp;
        cmpOp_e                cmpOp;
        logic                  aluSrcImm;     // operand b from immediate
        logic                  checkOverflow;
        logic                  branch;
        logic                  absJump;
        logic                  absJumpReg;    // target from regRead1
        logic                  memLoad;
        logic                  memStore;
        logic                  memSignExtend;
        memWidth_e             memWidth;
        exc_e                  exception;
        word_t                 immediate;
    } decodeCtrl_t;

    localparam decodeCtrl_t ctrlNop = '{
        regRead1:      '0,
        regRead2:      '0,
        destReg:       '0,
        wbSrc:         wbNone,
        aluOp:         aluAdd,
        cmpOp:         cmpNone,
        aluSrcImm:     1'b0,
        checkOverflow: 1'b0,
        branch:        1'b0,
        absJump:       1'b0,
        absJumpReg:    1'b0,
        memLoad:       1'b0,
        memStore:      1'b0,
        memSignExtend: 1'b0,
        memWidth:      memByte,
        exception:     excNone,
        immediate:     '0
    };

endpackage

/* src/specialDecoder.sv */
`timescale 1ns/1ns

module specialDecoder (
    input  logic                       clk,
    input  mipsIsaPkg::instrFields_t   fields,
    output decodeCtrlPkg::decodeCtrl_t ctrl
);

    mipsIsaPkg::funct_e funct;

    assign funct = fields.low.r.funct;

    function automatic decodeCtrlPkg::aluOp_e functAluOp(input mipsIsaPkg::funct_e fn);
        case (fn)
            mipsIsaPkg::fnSub, mipsIsaPkg::fnSubu: return decodeCtrlPkg::aluSub;
            mipsIsaPkg::fnAnd:                     return decodeCtrlPkg::aluAnd;
            mipsIsaPkg::fnOr:                      return decodeCtrlPkg::aluOr;
            mipsIsaPkg::fnNor:                     return decodeCtrlPkg::aluNor;
            mipsIsaPkg::fnXor:                     return decodeCtrlPkg::aluXor;
            mipsIsaPkg::fnSlt:                     return decodeCtrlPkg::aluSlt;
            mipsIsaPkg::fnSltu:                    return decodeCtrlPkg::aluSltu;
            mipsIsaPkg::fnSll, mipsIsaPkg::fnSllv: return decodeCtrlPkg::aluSll;
            mipsIsaPkg::fnSrl, mipsIsaPkg::fnSrlv: return decodeCtrlPkg::aluSrl;
            mipsIsaPkg::fnSra, mipsIsaPkg::fnSrav: return decodeCtrlPkg::aluSra;
            default:                               return decodeCtrlPkg::aluAdd;
        endcase
    endfunction

    always_comb
    begin
        ctrl = decodeCtrlPkg::ctrlNop;
        case (funct)
            mipsIsaPkg::fnAddu, mipsIsaPkg::fnSubu, mipsIsaPkg::fnAdd, mipsIsaPkg::fnSub,
            mipsIsaPkg::fnAnd, mipsIsaPkg::fnOr, mipsIsaPkg::fnNor, mipsIsaPkg::fnXor,
            mipsIsaPkg::fnSlt, mipsIsaPkg::fnSltu:
            begin
                ctrl.regRead1 = fields.rs;
                ctrl.regRead2 = fields.rt;
                ctrl.destReg = fields.low.r.rd;
                ctrl.wbSrc = decodeCtrlPkg::wbAlu;
                ctrl.aluOp = functAluOp(funct);
                ctrl.checkOverflow = funct inside {mipsIsaPkg::fnAdd, mipsIsaPkg::fnSub};
            end
            mipsIsaPkg::fnSll, mipsIsaPkg::fnSrl, mipsIsaPkg::fnSra:
            begin
                ctrl.regRead1 = fields.rt;
                ctrl.destReg = fields.low.r.rd;
                ctrl.wbSrc = decodeCtrlPkg::wbAlu;
                ctrl.aluOp = functAluOp(funct);
                ctrl.aluSrcImm = 1'b1;
                ctrl.immediate = decodeCtrlPkg::word_t'(fields.low.r.shamt);
            end
            mipsIsaPkg::fnSllv, mipsIsaPkg::fnSrlv, mipsIsaPkg::fnSrav:
            begin
                ctrl.regRead1 = fields.rt;
                ctrl.regRead2 = fields.rs;   // shift amount
                ctrl.destReg = fields.low.r.rd;
                ctrl.wbSrc = decodeCtrlPkg::wbAlu;
                ctrl.aluOp = functAluOp(funct);
            end
            mipsIsaPkg::fnJr, mipsIsaPkg::fnJalr:
            begin
                ctrl.regRead1 = fields.rs;
                ctrl.absJump = 1'b1;
                ctrl.absJumpReg = 1'b1;
                if (funct == mipsIsaPkg::fnJalr)
                begin
                    ctrl.wbSrc = decodeCtrlPkg::wbPc;  // link into rd
                    ctrl.destReg = fields.low.r.rd;
                end
            end
            mipsIsaPkg::fnSyscall: ctrl.exception = decodeCtrlPkg::excSyscall;
            mipsIsaPkg::fnBreak:   ctrl.exception = decodeCtrlPkg::excBreak;
            default:               ctrl.exception = decodeCtrlPkg::excUnknown;
        endcase
    end

    // shamt only reaches the ALU through the immediate path
    fixedShiftUsesImm: assert property (@(posedge clk)
        funct inside {mipsIsaPkg::fnSll, mipsIsaPkg::fnSrl, mipsIsaPkg::fnSra}
        |-> ctrl.aluSrcImm);

endmodule

/* src/opcodeDecoder.sv */
`timescale 1ns/1ns
`include "decoder_defs.svh"

module opcodeDecoder (
    input  logic                       clk,
    input  mipsIsaPkg::instrFields_t   fields,
    output decodeCtrlPkg::decodeCtrl_t ctrl
);

    decodeCtrlPkg::decodeCtrl_t specialCtrl;
    mipsIsaPkg::regimm_e regimm;
    logic [`DATA_W-1:0] signExtImm;
    logic [`DATA_W-1:0] zeroExtImm;
    logic [`DATA_W-1:0] upperImm;
    logic [`DATA_W-1:0] jumpImm;

    assign regimm = mipsIsaPkg::regimm_e'(fields.rt);
    assign signExtImm = {{(`DATA_W-`IMM_W){fields.low.imm16[`IMM_W-1]}}, fields.low.imm16};
    assign zeroExtImm = {{(`DATA_W-`IMM_W){1'b0}}, fields.low.imm16};
    assign upperImm = {fields.low.imm16, {(`DATA_W-`IMM_W){1'b0}}};
    assign jumpImm = {{(`DATA_W-`JUMP_IDX_W){1'b0}}, fields.rs, fields.rt, fields.low.imm16};

    specialDecoder funcDecode (
        .clk    (clk),
        .fields (fields),
        .ctrl   (specialCtrl)
    );

    // access width shared by loads and stores
    function automatic decodeCtrlPkg::memWidth_e accessWidth(input mipsIsaPkg::opcode_e op);
        case (op)
            mipsIsaPkg::opLb, mipsIsaPkg::opLbu, mipsIsaPkg::opSb: return decodeCtrlPkg::memByte;
            mipsIsaPkg::opLh, mipsIsaPkg::opLhu, mipsIsaPkg::opSh: return decodeCtrlPkg::memHalf;
            default:                                               return decodeCtrlPkg::memWord;
        endcase
    endfunction

    always_comb
    begin
        ctrl = decodeCtrlPkg::ctrlNop;
        case (fields.opcode)
            mipsIsaPkg::opSpecial: ctrl = specialCtrl;
            mipsIsaPkg::opAddi, mipsIsaPkg::opAddiu, mipsIsaPkg::opSlti, mipsIsaPkg::opSltiu,
            mipsIsaPkg::opAndi, mipsIsaPkg::opOri, mipsIsaPkg::opXori, mipsIsaPkg::opLui:
            begin
                ctrl.regRead1 = fields.rs;
                ctrl.destReg = fields.rt;
                ctrl.aluSrcImm = 1'b1;
                ctrl.wbSrc = decodeCtrlPkg::wbAlu;
                ctrl.immediate = signExtImm;
                ctrl.checkOverflow = fields.opcode == mipsIsaPkg::opAddi;
                case (fields.opcode)
                    mipsIsaPkg::opAddi, mipsIsaPkg::opAddiu: ctrl.aluOp = decodeCtrlPkg::aluAdd;
                    mipsIsaPkg::opSlti:  ctrl.aluOp = decodeCtrlPkg::aluSlt;
                    mipsIsaPkg::opSltiu: ctrl.aluOp = decodeCtrlPkg::aluSltu;
                    mipsIsaPkg::opAndi:
                    begin
                        ctrl.aluOp = decodeCtrlPkg::aluAnd;
                        ctrl.immediate = zeroExtImm;
                    end
                    mipsIsaPkg::opOri:
                    begin
                        ctrl.aluOp = decodeCtrlPkg::aluOr;
                        ctrl.immediate = zeroExtImm;
                    end
                    mipsIsaPkg::opXori:
                    begin
                        ctrl.aluOp = decodeCtrlPkg::aluXor;
                        ctrl.immediate = zeroExtImm;
                    end
                    default:  // lui
                    begin
                        ctrl.aluOp = decodeCtrlPkg::aluAdd;
                        ctrl.immediate = upperImm;
                    end
                endcase
            end
            mipsIsaPkg::opLb, mipsIsaPkg::opLh, mipsIsaPkg::opLw, mipsIsaPkg::opLbu,
            mipsIsaPkg::opLhu:
            begin
                ctrl.regRead1 = fields.rs;
                ctrl.destReg = fields.rt;
                ctrl.wbSrc = decodeCtrlPkg::wbMem;
                ctrl.memLoad = 1'b1;
                ctrl.memWidth = accessWidth(fields.opcode);
                ctrl.memSignExtend = fields.opcode inside {mipsIsaPkg::opLb, mipsIsaPkg::opLh};
                ctrl.immediate = signExtImm;
            end
            mipsIsaPkg::opSb, mipsIsaPkg::opSh, mipsIsaPkg::opSw:
            begin
                ctrl.regRead1 = fields.rs;
                ctrl.regRead2 = fields.rt;  // store data
                ctrl.memStore = 1'b1;
                ctrl.memWidth = accessWidth(fields.opcode);
                ctrl.immediate = signExtImm;
            end
            mipsIsaPkg::opBeq, mipsIsaPkg::opBne, mipsIsaPkg::opBlez, mipsIsaPkg::opBgtz:
            begin
                ctrl.regRead1 = fields.rs;
                ctrl.branch = 1'b1;
                ctrl.immediate = signExtImm;
                case (fields.opcode)
                    mipsIsaPkg::opBeq:
                    begin
                        ctrl.regRead2 = fields.rt;
                        ctrl.cmpOp = decodeCtrlPkg::cmpEq;
                    end
                    mipsIsaPkg::opBne:
                    begin
                        ctrl.regRead2 = fields.rt;
                        ctrl.cmpOp = decodeCtrlPkg::cmpNe;
                    end
                    mipsIsaPkg::opBlez: ctrl.cmpOp = decodeCtrlPkg::cmpLez;
                    default:            ctrl.cmpOp = decodeCtrlPkg::cmpGtz;  // bgtz
                endcase
            end
            mipsIsaPkg::opRegimm:
            begin
                case (regimm)
                    mipsIsaPkg::riBltz, mipsIsaPkg::riBgez, mipsIsaPkg::riBltzal,
                    mipsIsaPkg::riBgezal:
                    begin
                        ctrl.regRead1 = fields.rs;
                        ctrl.branch = 1'b1;
                        ctrl.immediate = signExtImm;
                        if (regimm inside {mipsIsaPkg::riBltz, mipsIsaPkg::riBltzal})
                            ctrl.cmpOp = decodeCtrlPkg::cmpLtz;
                        else
                            ctrl.cmpOp = decodeCtrlPkg::cmpGez;
                        if (regimm inside {mipsIsaPkg::riBltzal, mipsIsaPkg::riBgezal})
                        begin
                            ctrl.wbSrc = decodeCtrlPkg::wbPc;
                            ctrl.destReg = `REG_IDX_W'(`LINK_REG);
                        end
                    end
                    default: ctrl.exception = decodeCtrlPkg::excUnknown;
                endcase
            end
            mipsIsaPkg::opJ, mipsIsaPkg::opJal:
            begin
                ctrl.absJump = 1'b1;
                ctrl.immediate = jumpImm;  // word index, pc region added later
                if (fields.opcode == mipsIsaPkg::opJal)
                begin
                    ctrl.wbSrc = decodeCtrlPkg::wbPc;
                    ctrl.destReg = `REG_IDX_W'(`LINK_REG);
                end
            end
            default: ctrl.exception = decodeCtrlPkg::excUnknown;
        endcase
    end

    loadStoreExclusive: assert property (@(posedge clk) !(ctrl.memLoad && ctrl.memStore));

endmodule

/* src/instrDecoder.sv */
`timescale 1ns/1ns
`include "decoder_defs.svh"

module instrDecoder (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       instrValid,
    input  logic [`DATA_W-1:0]         instr,
    output logic                       ctrlValid,
    output decodeCtrlPkg::decodeCtrl_t ctrl
);

    mipsIsaPkg::instrFields_t fields;
    decodeCtrlPkg::decodeCtrl_t nextCtrl;

    assign fields = mipsIsaPkg::instrFields_t'(instr);

    opcodeDecoder opDecode (
        .clk    (clk),
        .fields (fields),
        .ctrl   (nextCtrl)
    );

    // decode stage register, ctrl holds between strobes
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            ctrlValid <= 1'b0;
            ctrl <= decodeCtrlPkg::ctrlNop;
        end
        else
        begin
            ctrlValid <= instrValid;
            if (instrValid)
            begin
                ctrl <= nextCtrl;
            end
        end
    end

    // a second valid cycle needs a fresh strobe behind it
    validNeedsStrobe: assert property (@(posedge clk) disable iff (!rstN)
        ctrlValid |=> (!ctrlValid || $past(instrValid)));

endmodule

/* tests/instrDecoderTb.sv */
`timescale 1ns/1ns
`include "decoder_defs.svh"

module instrDecoderTb;

    localparam int MaxVectors = 64;
    localparam int DriveDelay = 5;  // ns after the rising edge
    localparam int CtrlW = $bits(decodeCtrlPkg::decodeCtrl_t);
    localparam decodeCtrlPkg::decodeCtrl_t ResetCtrl = '0;  // all fields zero, none or byte

    logic                       clk;
    logic                       rstN;
    logic                       instrValid;
    logic [`DATA_W-1:0]         instr;
    logic                       ctrlValid;
    decodeCtrlPkg::decodeCtrl_t ctrl;

    logic [CtrlW-1:0] vecMem [0:2*MaxVectors-1];  // instr word, then expected ctrl

    decodeCtrlPkg::decodeCtrl_t heldCtrl;  // last expected word that ctrl must hold
    logic [31:0] randState;
    int numVectors;
    int vecIdx;
    int valueErrors = 0;
    int validErrors = 0;
    int setupErrors = 0;
    int cycleCount = 0;
    int cycleLimit = 1000;

    instrDecoder UUT (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .ctrlValid  (ctrlValid),
        .ctrl       (ctrl)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("timeout after %0d cycles, the vector run did not complete", cycleCount);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic loadVectors();
        for (int a = 0; a < 2*MaxVectors; a++)
        begin
            vecMem[a] = {{(CtrlW-32){1'b1}}, 32'(a)};  // empty slots have all-ones top bits
        end
        $readmemh("tests/decode_testdata.txt", vecMem);
        numVectors = 0;
        while (numVectors < MaxVectors && vecMem[2*numVectors][CtrlW-1:32] != '1)
            numVectors++;
        if (numVectors == 0)
        begin
            setupErrors++;
            $display("no vectors could be read from tests/decode_testdata.txt");
        end
        cycleLimit = numVectors * 5 + 20;
    endtask

    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp)
        begin
            valueErrors++;
            $display("mismatch at %0t ns: %s is %0h, expected %0h (vector %0d)",
                     $time, name, got, exp, vecIdx);
        end
    endtask

    task automatic verifyCtrl(input decodeCtrlPkg::decodeCtrl_t exp);
        compareField("regRead1", 32'(ctrl.regRead1), 32'(exp.regRead1));
        compareField("regRead2", 32'(ctrl.regRead2), 32'(exp.regRead2));
        compareField("destReg", 32'(ctrl.destReg), 32'(exp.destReg));
        compareField("wbSrc", 32'(ctrl.wbSrc), 32'(exp.wbSrc));
        compareField("aluOp", 32'(ctrl.aluOp), 32'(exp.aluOp));
        compareField("cmpOp", 32'(ctrl.cmpOp), 32'(exp.cmpOp));
        compareField("aluSrcImm", 32'(ctrl.aluSrcImm), 32'(exp.aluSrcImm));
        compareField("checkOverflow", 32'(ctrl.checkOverflow), 32'(exp.checkOverflow));
        compareField("branch", 32'(ctrl.branch), 32'(exp.branch));
        compareField("absJump", 32'(ctrl.absJump), 32'(exp.absJump));
        compareField("absJumpReg", 32'(ctrl.absJumpReg), 32'(exp.absJumpReg));
        compareField("memLoad", 32'(ctrl.memLoad), 32'(exp.memLoad));
        compareField("memStore", 32'(ctrl.memStore), 32'(exp.memStore));
        compareField("memSignExtend", 32'(ctrl.memSignExtend), 32'(exp.memSignExtend));
        compareField("memWidth", 32'(ctrl.memWidth), 32'(exp.memWidth));
        compareField("exception", 32'(ctrl.exception), 32'(exp.exception));
        compareField("immediate", ctrl.immediate, exp.immediate);
    endtask

    // drive one cycle, then check what the edge loaded
    task automatic runCycle(input logic valid, input logic [31:0] word,
                            input decodeCtrlPkg::decodeCtrl_t exp);
        instrValid = valid;
        instr = word;
        @(posedge clk);
        #DriveDelay;
        if (ctrlValid !== valid)
        begin
            validErrors++;
            $display("mismatch at %0t ns: ctrlValid is %0b, expected %0b (vector %0d)",
                     $time, ctrlValid, valid, vecIdx);
        end
        if (valid)
            heldCtrl = exp;
        verifyCtrl(heldCtrl);
    endtask

    task automatic idleCycle();
        randState = nextRandom(randState);
        runCycle(1'b0, randState, heldCtrl);  // garbage word must not reach ctrl
    endtask

    initial
    begin
        clk = 1'b0;
        rstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        randState = 32'h7e4f;
        heldCtrl = ResetCtrl;
        vecIdx = -1;
        loadVectors();

        repeat (3) @(posedge clk);
        #DriveDelay;
        if (ctrlValid !== 1'b0)
        begin
            validErrors++;
            $display("mismatch at %0t ns: ctrlValid is high during reset", $time);
        end
        verifyCtrl(ResetCtrl);
        rstN = 1'b1;

        for (vecIdx = 0; vecIdx < numVectors; vecIdx++)
        begin
            randState = nextRandom(randState);
            repeat (randState[17:16]) idleCycle();  // 0 gives back-to-back strobes
            runCycle(1'b1, vecMem[2*vecIdx][31:0],
                     decodeCtrlPkg::decodeCtrl_t'(vecMem[2*vecIdx+1]));
        end
        idleCycle();

        $display("%0d vectors, %0d value errors, %0d valid errors, %0d setup errors",
                 numVectors, valueErrors, validErrors, setupErrors);
        if (valueErrors == 0 && validErrors == 0 && setupErrors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

/* tests/decode_testdata.txt */
// columns: instruction word, expected decodeCtrl_t as 68-bit hex
// ctrl layout from the top: regRead1 regRead2 destReg wbSrc aluOp cmpOp flags width exc, imm32
00221821 08868000000000000 // addu $3,$1,$2
00221820 08868040000000000 // add $3,$1,$2
00221822 08868840000000000 // sub $3,$1,$2
00221824 08869000000000000 // and $3,$1,$2
0022182A 0886B000000000000 // slt $3,$1,$2
00021940 1006C080000000005 // sll $3,$2,5
00021FC3 1006D08000000001F // sra $3,$2,31
00221804 1046C000000000000 // sllv $3,$2,$1
00200008 08000018000000000 // jr $1
00202809 080B8018000000000 // jalr $5,$1
0000000C 00000000100000000 // syscall
0000000D 00000000200000000 // break
00220018 00000000300000000 // mult, dropped
00220034 00000000300000000 // teq, dropped trap
2422FFFC 080480800FFFFFFFC // addiu $2,$1,-4
2022FFFC 080480C00FFFFFFFC // addi $2,$1,-4
30228001 08049080000008001 // andi $2,$1,0x8001
28228000 0804B0800FFFF8000 // slti $2,$1,0x8000
3C021234 00048080012340000 // lui $2,0x1234
8C22FFF8 080500048FFFFFFF8 // lw $2,-8($1)
84220010 08050005400000010 // lh $2,16($1)
9022FFFF 080500040FFFFFFFF // lbu $2,-1($1)
AC220004 08800002800000004 // sw $2,4($1)
A422FFFE 088000024FFFFFFFE // sh $2,-2($1)
A0220003 08800002000000003 // sb $2,3($1)
1022FFFF 088001200FFFFFFFF // beq $1,$2,-1
14220020 08800220000000020 // bne $1,$2,32
18200008 08000520000000008 // blez $1,8
1C20FFF0 080006200FFFFFFF0 // bgtz $1,-16
04200004 08000320000000004 // bltz $1,4
0431FFFC 083F84200FFFFFFFC // bgezal $1,-4
08123456 00000010000123456 // j 0x0123456
0FFFFFFF 003F8010003FFFFFF // jal 0x3ffffff
50220001 00000000300000000 // beql, dropped
88220000 00000000300000000 // lwl, dropped
BC200000 00000000300000000 // cache, dropped
40026000 00000000300000000 // mfc0 $2,$12, dropped
FC000000 00000000300000000 // opcode 0x3f, undefined

/* compile.f */
+incdir+include
src/mipsIsaPkg.sv
src/decodeCtrlPkg.sv
src/specialDecoder.sv
src/opcodeDecoder.sv
src/instrDecoder.sv
tests/instrDecoderTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = instrDecoderTb
FILELIST  = compile.f
OBJDIR    = obj_dir
LOG       = sim.log
FAILMSG   = tests failed
PASSMSG   = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASSMSG)" $(LOG); then echo "FAIL: no pass line in $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJDIR) $(LOG)
